// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module dmaControllerTb -f build.f -o simv
	./obj_dir/simv > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

// File: build.f
src/dmaPkg.sv
src/dmaRegisterFile.sv
src/dmaPriorityLogic.sv
src/dmaTimingControl.sv
src/dmaController.sv
verification/dmaControllerTb.sv

// File: src/dmaController.sv
`default_nettype none

module dmaController #(
  parameter int channelCount = dmaPkg::numChannels
) (
  input logic busIf,
  input logic reset,
  input dmaPkg::cpuBusT cpuBus,
  input dmaPkg::requestT dreq,
  input logic hlda,
  output dmaPkg::dmaBusT dmaBus,
  output dmaPkg::byteT dbOut
);

  // register file to priority logic
  dmaPkg::requestT tcFlags;
  logic rotatePriority;
  logic controllerDisable;

  // priority logic to timing control
  logic anyRequest;
  dmaPkg::channelT winner;

  // timing control back to the other two
  dmaPkg::channelT activeChannel;
  logic transferDone;

  // register file to timing control
  dmaPkg::wordT currentAddress;
  dmaPkg::transferTypeE transferType;
  dmaPkg::byteT cpuReadData;

  dmaRegisterFile #(
    .channelCount(channelCount)
  ) u_registerFile (
    .busIf(busIf),
    .reset(reset),
    .cpuBus(cpuBus),
    .activeChannel(activeChannel),
    .transferDone(transferDone),
    .cpuReadData(cpuReadData),
    .currentAddress(currentAddress),
    .transferType(transferType),
    .tcFlags(tcFlags),
    .rotatePriority(rotatePriority),
    .controllerDisable(controllerDisable)
  );

  dmaPriorityLogic #(
    .channelCount(channelCount)
  ) u_priorityLogic (
    .busIf(busIf),
    .reset(reset),
    .dreq(dreq),
    .tcFlags(tcFlags),
    .rotatePriority(rotatePriority),
    .controllerDisable(controllerDisable),
    .transferDone(transferDone),
    .activeChannel(activeChannel),
    .anyRequest(anyRequest),
    .winner(winner)
  );

  dmaTimingControl u_timingControl (
    .busIf(busIf),
    .reset(reset),
    .anyRequest(anyRequest),
    .winner(winner),
    .hlda(hlda),
    .currentAddress(currentAddress),
    .transferType(transferType),
    .cpuReadData(cpuReadData),
    .activeChannel(activeChannel),
    .transferDone(transferDone),
    .dmaBus(dmaBus),
    .dbOut(dbOut)
  );

endmodule

`default_nettype wire

// File: src/dmaPkg.sv
`default_nettype none

package dmaPkg;

  // four request/acknowledge channel pairs
  localparam int numChannels = 4;

  // data bus byte and the 16 bit address and count words
  typedef logic [7:0] byteT;
  typedef logic [15:0] wordT;

  // channel index and the one bit per channel vectors
  typedef logic [1:0] channelT;
  typedef logic [numChannels-1:0] requestT;

  // cpu side register select lines
  typedef logic [3:0] regAddrT;

  // transfer type field of the mode register, 3 is unused
  typedef enum logic [1:0] {
    verifyXfer = 2'd0,
    writeXfer  = 2'd1,
    readXfer   = 2'd2
  } transferTypeE;

  // 8237 timing states, S3 is not needed for single transfers
  typedef enum logic [2:0] {
    stateSI,
    stateSO,
    stateS1,
    stateS2,
    stateS4
  } timingStateE;

  // register offsets above the eight channel registers
  localparam regAddrT regCommand = 4'd8;
  // status is the read side of the command offset
  localparam regAddrT regStatus = 4'd8;
  localparam regAddrT regMode = 4'd11;
  localparam regAddrT regClearFlipFlop = 4'd12;

  // rank 0 holds the channel with the highest priority
  typedef channelT [numChannels-1:0] priorityOrderT;
  localparam priorityOrderT resetPriorityOrder = {2'd3, 2'd2, 2'd1, 2'd0};

  // cpu programming port
  typedef struct packed {
    logic csN;
    logic iorN;
    logic iowN;
    regAddrT addr;
    byteT data;
  } cpuBusT;

  // dma side outputs while the controller owns the bus
  typedef struct packed {
    logic hrq;
    logic aen;
    logic adstb;
    logic iorN;
    logic iowN;
    logic memrN;
    logic memwN;
    requestT dack;
    byteT addressLow;
  } dmaBusT;

endpackage

`default_nettype wire

// File: src/dmaPriorityLogic.sv
`default_nettype none

module dmaPriorityLogic #(
  parameter int channelCount = dmaPkg::numChannels
) (
  input logic busIf,
  input logic reset,
  input dmaPkg::requestT dreq,
  input dmaPkg::requestT tcFlags,
  input logic rotatePriority,
  input logic controllerDisable,
  input logic transferDone,
  input dmaPkg::channelT activeChannel,
  output logic anyRequest,
  output dmaPkg::channelT winner
);

  // rank 0 is the highest priority channel
  dmaPkg::priorityOrderT order;
  dmaPkg::requestT maskedRequest;

  // drop finished channels, drop everything when disabled
  always_comb
  begin
    maskedRequest = dreq & ~tcFlags;
    if (controllerDisable)
    begin
      maskedRequest = '0;
    end
  end

  assign anyRequest = |maskedRequest;

  // walk from lowest rank up so the highest rank wins
  always_comb
  begin
    winner = order[0];
    for (int rank = channelCount - 1; rank >= 0; rank--)
    begin
      if (maskedRequest[order[rank]])
      begin
        winner = order[rank];
      end
    end
  end

  // fixed mode keeps the reset order
  // rotating mode puts the served channel last
  always_ff @(posedge busIf)
  begin
    if (reset || !rotatePriority)
    begin
      order <= dmaPkg::resetPriorityOrder;
    end
    else if (transferDone)
    begin
      for (int rank = 0; rank < channelCount; rank++)
      begin
        order[rank] <= dmaPkg::channelT'(activeChannel + rank + 1);
      end
    end
  end

  // winner has a live request and has not reached terminal count
  winnerIsRequesting: assert property (@(posedge busIf) disable iff (reset)
    anyRequest |-> (dreq[winner] && !tcFlags[winner]));

endmodule

`default_nettype wire

// File: src/dmaRegisterFile.sv
`default_nettype none

module dmaRegisterFile #(
  parameter int channelCount = dmaPkg::numChannels
) (
  input logic busIf,
  input logic reset,
  input dmaPkg::cpuBusT cpuBus,
  input dmaPkg::channelT activeChannel,
  input logic transferDone,
  output dmaPkg::byteT cpuReadData,
  output dmaPkg::wordT currentAddress,
  output dmaPkg::transferTypeE transferType,
  output dmaPkg::requestT tcFlags,
  output logic rotatePriority,
  output logic controllerDisable
);

  // per channel base and current registers
  dmaPkg::wordT [channelCount-1:0] baseAddressReg;
  dmaPkg::wordT [channelCount-1:0] baseCountReg;
  dmaPkg::wordT [channelCount-1:0] curAddressReg;
  dmaPkg::wordT [channelCount-1:0] curCountReg;
  dmaPkg::transferTypeE [channelCount-1:0] modeType;

  logic cpuWrite;
  logic cpuRead;
  logic isChannelReg;
  logic isCount;
  logic statusRead;
  logic bytePointer;
  dmaPkg::channelT chSel;
  dmaPkg::wordT readWord;

  // every strobe cycle counts as one access
  assign cpuWrite = !cpuBus.csN && !cpuBus.iowN;
  assign cpuRead = !cpuBus.csN && !cpuBus.iorN;

  // offsets 0..7 hit the channel registers
  assign isChannelReg = !cpuBus.addr[3];
  assign chSel = cpuBus.addr[2:1];
  assign isCount = cpuBus.addr[0];
  assign statusRead = cpuRead && (cpuBus.addr == dmaPkg::regStatus);

  // values seen by the timing block for the serving channel
  assign currentAddress = curAddressReg[activeChannel];
  assign transferType = modeType[activeChannel];

  // combinational readback with the byte chosen by the pointer
  always_comb
  begin
    readWord = isCount ? curCountReg[chSel] : curAddressReg[chSel];
    cpuReadData = '0;
    if (cpuRead && isChannelReg)
    begin
      cpuReadData = bytePointer ? readWord[15:8] : readWord[7:0];
    end
    else if (statusRead)
    begin
      cpuReadData = {4'b0000, tcFlags};
    end
  end

  // address and count arrays
  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      baseAddressReg <= '0;
      baseCountReg <= '0;
      curAddressReg <= '0;
      curCountReg <= '0;
    end
    else
    begin
      // one upward address step and one count step per finished transfer
      if (transferDone)
      begin
        curAddressReg[activeChannel] <= curAddressReg[activeChannel] + 16'd1;
        curCountReg[activeChannel] <= curCountReg[activeChannel] - 16'd1;
      end
      // a cpu write loads base and current together
      if (cpuWrite && isChannelReg)
      begin
        case ({isCount, bytePointer})
          2'b00:
          begin
            baseAddressReg[chSel][7:0] <= cpuBus.data;
            curAddressReg[chSel][7:0] <= cpuBus.data;
          end
          2'b01:
          begin
            baseAddressReg[chSel][15:8] <= cpuBus.data;
            curAddressReg[chSel][15:8] <= cpuBus.data;
          end
          2'b10:
          begin
            baseCountReg[chSel][7:0] <= cpuBus.data;
            curCountReg[chSel][7:0] <= cpuBus.data;
          end
          default:
          begin
            baseCountReg[chSel][15:8] <= cpuBus.data;
            curCountReg[chSel][15:8] <= cpuBus.data;
          end
        endcase
      end
    end
  end

  // pointer, command, mode and status
  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      bytePointer <= 1'b0;
      controllerDisable <= 1'b0;
      rotatePriority <= 1'b0;
      tcFlags <= '0;
      for (int ch = 0; ch < channelCount; ch++)
      begin
        modeType[ch] <= dmaPkg::verifyXfer;
      end
    end
    else
    begin
      if (cpuWrite && (cpuBus.addr == dmaPkg::regClearFlipFlop))
      begin
        bytePointer <= 1'b0;
      end
      else if ((cpuWrite || cpuRead) && isChannelReg)
      begin
        bytePointer <= !bytePointer;
      end
      // command bit 2 disables and bit 4 selects rotation
      if (cpuWrite && (cpuBus.addr == dmaPkg::regCommand))
      begin
        controllerDisable <= cpuBus.data[2];
        rotatePriority <= cpuBus.data[4];
      end
      // mode bits 1:0 pick the channel and bits 3:2 the transfer type
      if (cpuWrite && (cpuBus.addr == dmaPkg::regMode))
      begin
        modeType[cpuBus.data[1:0]] <= dmaPkg::transferTypeE'(cpuBus.data[3:2]);
      end
      // a status read clears the flags but a new terminal count still lands
      if (statusRead)
      begin
        tcFlags <= '0;
      end
      if (transferDone && (curCountReg[activeChannel] == '0))
      begin
        tcFlags[activeChannel] <= 1'b1;
      end
    end
  end

  // pointer is back on the low byte after a clear command
  pointerCleared: assert property (@(posedge busIf) disable iff (reset)
    (cpuWrite && (cpuBus.addr == dmaPkg::regClearFlipFlop)) |=> !bytePointer);

  // flags move only with a finished transfer or a status read
  tcFlagsOnEvents: assert property (@(posedge busIf) disable iff (reset)
    !(transferDone || statusRead) |=> $stable(tcFlags));

endmodule

`default_nettype wire

// File: src/dmaTimingControl.sv
`default_nettype none

module dmaTimingControl (
  input logic busIf,
  input logic reset,
  input logic anyRequest,
  input dmaPkg::channelT winner,
  input logic hlda,
  input dmaPkg::wordT currentAddress,
  input dmaPkg::transferTypeE transferType,
  input dmaPkg::byteT cpuReadData,
  output dmaPkg::channelT activeChannel,
  output logic transferDone,
  output dmaPkg::dmaBusT dmaBus,
  output dmaPkg::byteT dbOut
);

  dmaPkg::timingStateE state;
  dmaPkg::timingStateE nextState;

  // single transfer sequence, only SO may stall
  always_comb
  begin
    nextState = state;
    case (state)
      dmaPkg::stateSI:
      begin
        // wait until the cpu has released hlda from the last cycle
        if (anyRequest && !hlda)
        begin
          nextState = dmaPkg::stateSO;
        end
      end
      dmaPkg::stateSO:
      begin
        if (hlda)
        begin
          nextState = dmaPkg::stateS1;
        end
      end
      dmaPkg::stateS1:
      begin
        nextState = dmaPkg::stateS2;
      end
      dmaPkg::stateS2:
      begin
        nextState = dmaPkg::stateS4;
      end
      default:
      begin
        nextState = dmaPkg::stateSI;
      end
    endcase
  end

  always_ff @(posedge busIf)
  begin
    if (reset)
    begin
      state <= dmaPkg::stateSI;
      activeChannel <= '0;
    end
    else
    begin
      state <= nextState;
      // channel is fixed for the whole cycle once hrq goes out
      if ((state == dmaPkg::stateSI) && (nextState == dmaPkg::stateSO))
      begin
        activeChannel <= winner;
      end
    end
  end

  // registers step at the end of S4
  assign transferDone = (state == dmaPkg::stateS4);

  // high address byte goes out on the data bus for the external latch
  assign dbOut = (state == dmaPkg::stateS1) ? currentAddress[15:8] : cpuReadData;

  // bus outputs decoded from the state
  always_comb
  begin
    dmaBus = '0;
    dmaBus.iorN = 1'b1;
    dmaBus.iowN = 1'b1;
    dmaBus.memrN = 1'b1;
    dmaBus.memwN = 1'b1;
    dmaBus.hrq = (state == dmaPkg::stateSO) || (state == dmaPkg::stateS1) ||
                 (state == dmaPkg::stateS2);
    if ((state == dmaPkg::stateS1) || (state == dmaPkg::stateS2))
    begin
      dmaBus.aen = 1'b1;
      dmaBus.dack[activeChannel] = 1'b1;
      dmaBus.addressLow = currentAddress[7:0];
    end
    // address strobe only in the first bus state
    dmaBus.adstb = (state == dmaPkg::stateS1);
    if (state == dmaPkg::stateS2)
    begin
      case (transferType)
        dmaPkg::writeXfer:
        begin
          // device to memory
          dmaBus.iorN = 1'b0;
          dmaBus.memwN = 1'b0;
        end
        dmaPkg::readXfer:
        begin
          // memory to device
          dmaBus.memrN = 1'b0;
          dmaBus.iowN = 1'b0;
        end
        default:
        begin
          // verify, no strobes
        end
      endcase
    end
  end

  // I/O read and write strobes are never active together
  ioStrobesExclusive: assert property (@(posedge busIf) disable iff (reset)
    !(!dmaBus.iorN && !dmaBus.iowN));

  // address strobe is a single cycle pulse
  adstbOneCycle: assert property (@(posedge busIf) disable iff (reset)
    $rose(dmaBus.adstb) |=> !dmaBus.adstb);

endmodule

`default_nettype wire

// File: verification/dmaControllerTb.sv
`default_nettype none

module dmaControllerTb;
  timeunit 1ns;
  timeprecision 1ps;

  // transfers in each test phase
  localparam int fixedTransfers = 40;
  localparam int rotateTransfers = 5;
  localparam int tcTransfers = 3;
  // SI through S4 plus the hold handshake, with some slack
  localparam int transferCycles = 10;
  // 13 channel programs or checks of five accesses, then mode, command and status
  localparam int regAccesses = 13 * 5 + 4 + 2 + 2;
  // reset, idle stretches, two cycles per register access, then the transfers
  localparam int testCycles = 10 + 30 + 2 * regAccesses +
    transferCycles * (fixedTransfers + rotateTransfers + tcTransfers);

  logic busIf = 1'b0;
  logic reset;
  dmaPkg::cpuBusT cpuBus;
  dmaPkg::requestT dreq;
  logic hlda = 1'b0;
  dmaPkg::dmaBusT dmaBus;
  dmaPkg::byteT dbOut;

  int errorCount = 0;
  logic [7:0] lfsrState;

  // expectations shared with the checkers
  logic readCheck;
  dmaPkg::byteT readExpect;
  dmaPkg::requestT expectDack;
  dmaPkg::wordT expectAddr;
  logic [3:0] expectStrobes;
  logic tcIdle;

  // what the cpu programmed and the transfers done since then
  dmaPkg::wordT progAddr [4];
  dmaPkg::wordT doneCount [4];
  dmaPkg::transferTypeE xferType [4];

  // strobes as {iorN, iowN, memrN, memwN}
  logic [3:0] strobes;
  assign strobes = {dmaBus.iorN, dmaBus.iowN, dmaBus.memrN, dmaBus.memwN};

  dmaController #(
    .channelCount(dmaPkg::numChannels)
  ) u_dmaController (
    .busIf(busIf),
    .reset(reset),
    .cpuBus(cpuBus),
    .dreq(dreq),
    .hlda(hlda),
    .dmaBus(dmaBus),
    .dbOut(dbOut)
  );

  always #4 busIf = ~busIf;

  // cpu side grants the bus one cycle after hrq and releases it with hrq
  always @(posedge busIf)
  begin
    if (reset)
      hlda <= 1'b0;
    else
      hlda <= dmaBus.hrq;
  end

  // taps 8 6 5 4
  function automatic logic [7:0] lfsrNext(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // one lfsr step per request bit
  task automatic drawRequest(output dmaPkg::requestT r);
    for (int i = 0; i < 4; i++)
    begin
      lfsrState = lfsrNext(lfsrState);
      r[i] = lfsrState[0];
    end
  endtask

  // strobe pattern in S2 for each transfer type
  function automatic logic [3:0] strobesFor(input dmaPkg::transferTypeE t);
    case (t)
      dmaPkg::writeXfer: return 4'b0110;
      dmaPkg::readXfer: return 4'b1001;
      default: return 4'b1111;
    endcase
  endfunction

  task automatic writeReg(input dmaPkg::regAddrT a, input dmaPkg::byteT d);
    @(posedge busIf);
    cpuBus <= {1'b0, 1'b1, 1'b0, a, d};
    @(posedge busIf);
    cpuBus <= {1'b1, 1'b1, 1'b1, 4'h0, 8'h00};
  endtask

  // the checker samples dbOut at the end of the strobe cycle
  task automatic readReg(input dmaPkg::regAddrT a, input dmaPkg::byteT e);
    @(posedge busIf);
    cpuBus <= {1'b0, 1'b0, 1'b1, a, 8'h00};
    readCheck <= 1'b1;
    readExpect <= e;
    @(posedge busIf);
    cpuBus <= {1'b1, 1'b1, 1'b1, 4'h0, 8'h00};
    readCheck <= 1'b0;
  endtask

  task automatic programChannel(input dmaPkg::channelT ch, input dmaPkg::wordT a,
                                input dmaPkg::wordT n);
    writeReg(dmaPkg::regClearFlipFlop, 8'h00);
    writeReg({1'b0, ch, 1'b0}, a[7:0]);
    writeReg({1'b0, ch, 1'b0}, a[15:8]);
    writeReg({1'b0, ch, 1'b1}, n[7:0]);
    writeReg({1'b0, ch, 1'b1}, n[15:8]);
    progAddr[ch] = a;
    doneCount[ch] = '0;
  endtask

  task automatic checkChannel(input dmaPkg::channelT ch, input dmaPkg::wordT a,
                              input dmaPkg::wordT n);
    writeReg(dmaPkg::regClearFlipFlop, 8'h00);
    readReg({1'b0, ch, 1'b0}, a[7:0]);
    readReg({1'b0, ch, 1'b0}, a[15:8]);
    readReg({1'b0, ch, 1'b1}, n[7:0]);
    readReg({1'b0, ch, 1'b1}, n[15:8]);
  endtask

  task automatic setMode(input dmaPkg::channelT ch, input dmaPkg::transferTypeE t);
    writeReg(dmaPkg::regMode, {4'b0000, t, ch});
    xferType[ch] = t;
  endtask

  // raise dreq and follow one transfer until hrq drops in S4
  task automatic runTransfer(input dmaPkg::requestT req, input dmaPkg::channelT ch);
    dmaPkg::wordT a;
    a = progAddr[ch] + doneCount[ch];
    @(posedge busIf);
    dreq <= req;
    expectDack <= dmaPkg::requestT'(4'b0001 << ch);
    expectAddr <= a;
    expectStrobes <= strobesFor(xferType[ch]);
    @(negedge busIf);
    while (!dmaBus.aen)
      @(negedge busIf);
    while (dmaBus.hrq)
      @(negedge busIf);
    doneCount[ch] = doneCount[ch] + 16'd1;
  endtask

  initial
  begin
    dmaPkg::requestT r;
    dmaPkg::channelT ch;
    reset = 1'b1;
    cpuBus = {1'b1, 1'b1, 1'b1, 4'h0, 8'h00};
    dreq = '0;
    readCheck = 1'b0;
    readExpect = '0;
    expectDack = '0;
    expectAddr = '0;
    expectStrobes = 4'b1111;
    tcIdle = 1'b0;
    lfsrState = 8'd49;
    repeat (10) @(posedge busIf);
    reset <= 1'b0;

    // everything reads zero after reset
    for (int c = 0; c < 4; c++)
      checkChannel(dmaPkg::channelT'(c), 16'h0000, 16'h0000);

    // ch0 address carries into the high byte on the third transfer
    programChannel(2'd0, 16'h12FE, 16'h0100);
    programChannel(2'd1, 16'h3400, 16'h0100);
    programChannel(2'd2, 16'h56A0, 16'h0100);
    programChannel(2'd3, 16'h78C0, 16'h0100);
    setMode(2'd0, dmaPkg::writeXfer);
    setMode(2'd1, dmaPkg::readXfer);
    setMode(2'd2, dmaPkg::verifyXfer);
    setMode(2'd3, dmaPkg::writeXfer);
    for (int c = 0; c < 4; c++)
      checkChannel(dmaPkg::channelT'(c), progAddr[c], 16'h0100);

    // under fixed priority the lowest requesting channel wins
    for (int t = 0; t < fixedTransfers; t++)
    begin
      drawRequest(r);
      if (r == '0)
        r = 4'b0001;
      ch = 2'd3;
      for (int c = 3; c >= 0; c--)
        if (r[c])
          ch = dmaPkg::channelT'(c);
      runTransfer(r, ch);
    end

    // rotating priority walks through all four channels
    @(posedge busIf);
    dreq <= '0;
    writeReg(dmaPkg::regCommand, 8'h10);
    for (int t = 0; t < rotateTransfers; t++)
      runTransfer(4'b1111, dmaPkg::channelT'(t % 4));
    @(posedge busIf);
    dreq <= '0;
    writeReg(dmaPkg::regCommand, 8'h00);

    // count 2 gives three transfers before the channel is masked
    programChannel(2'd2, 16'h0200, 16'h0002);
    for (int t = 0; t < tcTransfers; t++)
      runTransfer(4'b0100, 2'd2);
    @(posedge busIf);
    dreq <= 4'b0100;
    tcIdle <= 1'b1;
    repeat (20) @(posedge busIf);
    tcIdle <= 1'b0;
    dreq <= '0;
    readReg(dmaPkg::regStatus, 8'h04);
    readReg(dmaPkg::regStatus, 8'h00);

    repeat (4) @(posedge busIf);
    $display("errors %0d", errorCount);
    if (errorCount == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

  initial
  begin
    #(testCycles * 8 + 2000);
    $display("timeout, the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  // idle bus right after reset
  resetOutputs: assert property (@(posedge busIf) $fell(reset) |->
    (!dmaBus.hrq && !dmaBus.aen && !dmaBus.adstb && dmaBus.dack == '0 && strobes == 4'hF))
  else
  begin
    errorCount++;
    $display("ERR %0t: bus not idle after reset", $time);
  end

  readbackValue: assert property (@(posedge busIf) disable iff (reset)
    readCheck |-> dbOut == readExpect)
  else
  begin
    errorCount++;
    $display("ERR %0t: read %h, expected %h", $time, $sampled(dbOut),
      $sampled(readExpect));
  end

  dackMatches: assert property (@(posedge busIf) disable iff (reset)
    $rose(dmaBus.aen) |-> (dmaBus.dack == expectDack && $onehot(dmaBus.dack)))
  else
  begin
    errorCount++;
    $display("ERR %0t: dack %b, expected %b", $time, $sampled(dmaBus.dack),
      $sampled(expectDack));
  end

  addressLowMatches: assert property (@(posedge busIf) disable iff (reset)
    $rose(dmaBus.aen) |-> dmaBus.addressLow == expectAddr[7:0])
  else
  begin
    errorCount++;
    $display("ERR %0t: low address %h, expected %h", $time,
      $sampled(dmaBus.addressLow), $sampled(expectAddr[7:0]));
  end

  // high byte on the data bus during the single strobe cycle
  adstbHighByte: assert property (@(posedge busIf) disable iff (reset)
    $rose(dmaBus.adstb) |-> dbOut == expectAddr[15:8] ##1 !dmaBus.adstb)
  else
  begin
    errorCount++;
    $display("ERR %0t: wrong adstb pulse or high byte", $time);
  end

  aenTwoCycles: assert property (@(posedge busIf) disable iff (reset)
    $rose(dmaBus.aen) |=> dmaBus.aen ##1 !dmaBus.aen)
  else
  begin
    errorCount++;
    $display("ERR %0t: aen not two cycles long", $time);
  end

  strobesInS1: assert property (@(posedge busIf) disable iff (reset)
    dmaBus.adstb |-> strobes == 4'b1111)
  else
  begin
    errorCount++;
    $display("ERR %0t: strobe active in S1", $time);
  end

  strobesInS2: assert property (@(posedge busIf) disable iff (reset)
    (dmaBus.aen && !dmaBus.adstb) |-> strobes == expectStrobes)
  else
  begin
    errorCount++;
    $display("ERR %0t: strobes %b, expected %b", $time, $sampled(strobes),
      $sampled(expectStrobes));
  end

  hrqDrops: assert property (@(posedge busIf) disable iff (reset)
    $fell(dmaBus.aen) |-> !dmaBus.hrq)
  else
  begin
    errorCount++;
    $display("ERR %0t: hrq still high after transfer", $time);
  end

  // a channel at terminal count gets no more service
  tcHoldsOff: assert property (@(posedge busIf) disable iff (reset)
    tcIdle |-> !dmaBus.hrq)
  else
  begin
    errorCount++;
    $display("ERR %0t: hrq raised after terminal count", $time);
  end

endmodule

`default_nettype wire
